// ==== design/ciPkg.sv ====
`default_nettype none

package ciPkg;

  // ####################################################################
  // Widths and opcodes of the custom-instruction port.
  // ####################################################################

  localparam int ciDataWidth   = 32;
  localparam int ciOpcodeWidth = 8;

  localparam logic [ciOpcodeWidth-1:0] ciOpByte    = 8'd1;
  localparam logic [ciOpcodeWidth-1:0] ciOpDelay   = 8'd6;
  localparam logic [ciOpcodeWidth-1:0] ciOpProfile = 8'd12;

  // Answer for any opcode that no unit claims.
  localparam logic [ciDataWidth-1:0] ciUnknownResult = {ciDataWidth{1'b1}};

  // ####################################################################
  // Request, response and internal routing.
  // ####################################################################

  typedef struct packed {
    logic [ciDataWidth-1:0] dataA;
    logic [ciDataWidth-1:0] dataB;
  } ciOperands_t;

  typedef struct packed {
    logic                     start;
    logic [ciOpcodeWidth-1:0] opcode;
    ciOperands_t              operands;
  } ciRequest_t;

  typedef struct packed {
    logic                   done;
    logic [ciDataWidth-1:0] result;
  } ciResponse_t;

  typedef struct packed {
    logic byteStart;
    logic delayStart;
    logic profileStart;
    logic unknownStart;
  } ciIssue_t;

  // Byte rearrangement selected by dataB bits 1..0.
  typedef enum logic [1:0] {
    reverseBytes = 2'd0,
    swapHalves   = 2'd1,
    swapInHalves = 2'd2,
    passThrough  = 2'd3
  } byteMode_t;

endpackage

`default_nettype wire

// ==== design/ciDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module ciDecoder #(
  parameter int resetStretchCycles = 16
) (
  input  wire                s_systemClock,
  input  wire                s_pllLocked,
  input  wire ciPkg::ciRequest_t request,
  output logic               ready,
  output ciPkg::ciIssue_t    issue
);

  import ciPkg::*;

  localparam int stretchWidth =
    (resetStretchCycles > 0) ? $clog2(resetStretchCycles + 1) : 1;
  localparam logic [stretchWidth-1:0] stretchLimit = stretchWidth'(resetStretchCycles);

  logic [stretchWidth-1:0] stretchCount;
  logic                    accepted;

  // ####################################################################
  // Reset stretch.
  // ####################################################################

  // The counter saturates at the limit, so ready stays high until the
  // next loss of lock.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      stretchCount <= '0;
    end else if (stretchCount != stretchLimit) begin
      stretchCount <= stretchCount + 1'b1;
    end
  end

  assign ready    = (stretchCount == stretchLimit);
  assign accepted = request.start & ready;

  // ####################################################################
  // Opcode routing.
  // ####################################################################

  always_comb begin
    issue = '0;
    if (accepted) begin
      case (request.opcode)
        ciOpByte:    issue.byteStart    = 1'b1;
        ciOpDelay:   issue.delayStart   = 1'b1;
        ciOpProfile: issue.profileStart = 1'b1;
        default:     issue.unknownStart = 1'b1;
      endcase
    end
  end

  // A start that is accepted must reach exactly one consumer downstream.
  issueOneHot : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    $onehot0(issue) and (accepted == (issue != '0))
  ) else $error("ciDecoder: issue is not one-hot for an accepted start");

endmodule

`default_nettype wire

// ==== design/ciByteUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module ciByteUnit (
  input  wire                 s_systemClock,
  input  wire                 s_pllLocked,
  input  wire                 start,
  input  wire ciPkg::ciOperands_t operands,
  output ciPkg::ciResponse_t  response
);

  import ciPkg::*;

  byteMode_t              mode;
  logic [ciDataWidth-1:0] swapped;

  assign mode = byteMode_t'(operands.dataB[1:0]);

  always_comb begin
    case (mode)
      reverseBytes: swapped = {operands.dataA[7:0], operands.dataA[15:8],
                               operands.dataA[23:16], operands.dataA[31:24]};
      swapHalves:   swapped = {operands.dataA[15:0], operands.dataA[31:16]};
      swapInHalves: swapped = {operands.dataA[23:16], operands.dataA[31:24],
                               operands.dataA[7:0], operands.dataA[15:8]};
      default:      swapped = operands.dataA;
    endcase
  end

  // The result only carries data in the cycle where done is high, so the
  // unit responses can simply be ORed further on.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      response <= '0;
    end else begin
      response.done   <= start;
      response.result <= start ? swapped : '0;
    end
  end

endmodule

`default_nettype wire

// ==== design/ciDelayUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module ciDelayUnit #(
  parameter int cyclesPerMicrosecond = 5
) (
  input  wire                 s_systemClock,
  input  wire                 s_pllLocked,
  input  wire                 start,
  input  wire ciPkg::ciOperands_t operands,
  output ciPkg::ciResponse_t  response
);

  import ciPkg::*;

  localparam int prescaleWidth =
    (cyclesPerMicrosecond > 1) ? $clog2(cyclesPerMicrosecond) : 1;
  localparam logic [prescaleWidth-1:0] prescaleReload =
    prescaleWidth'(cyclesPerMicrosecond - 1);

  logic                     busy;
  logic [ciDataWidth-1:0]   usCount;
  logic [prescaleWidth-1:0] prescaleCount;
  logic                     countExpired;

  // The remaining wait is usCount * cyclesPerMicrosecond + prescaleCount
  // cycles. Loading dataA - 1 at the start edge accounts for that edge.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      busy          <= 1'b0;
      usCount       <= '0;
      prescaleCount <= '0;
    end else if (start) begin
      busy <= 1'b1;
      if (operands.dataA == '0) begin
        usCount       <= '0;
        prescaleCount <= '0;
      end else begin
        usCount       <= operands.dataA - 1'b1;
        prescaleCount <= prescaleReload;
      end
    end else if (busy) begin
      if (countExpired) begin
        busy <= 1'b0;
      end else if (prescaleCount == '0) begin
        usCount       <= usCount - 1'b1;
        prescaleCount <= prescaleReload;
      end else begin
        prescaleCount <= prescaleCount - 1'b1;
      end
    end
  end

  assign countExpired    = busy && (usCount == '0) && (prescaleCount == '0);
  assign response.done   = countExpired;
  assign response.result = '0;

  noStartWhileCounting : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    busy |-> !start
  ) else $error("ciDelayUnit: start received while a delay is running");

endmodule

`default_nettype wire

// ==== design/ciProfileUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module ciProfileUnit (
  input  wire                 s_systemClock,
  input  wire                 s_pllLocked,
  input  wire                 start,
  input  wire ciPkg::ciOperands_t operands,
  input  wire                 stall,
  input  wire                 busIdle,
  output ciPkg::ciResponse_t  response
);

  import ciPkg::*;

  localparam int numCounters = 3;

  logic [numCounters-1:0]                  events;
  logic [numCounters-1:0]                  enables;
  logic [numCounters-1:0]                  clearMask;
  logic [numCounters-1:0][ciDataWidth-1:0] counters;
  logic [ciDataWidth-1:0]                  selected;

  // Counter 0 counts every cycle, 1 stall cycles and 2 bus idle cycles.
  assign events    = {busIdle, stall, 1'b1};
  assign clearMask = start ? operands.dataB[10:8] : '0;

  // ####################################################################
  // Counters and their control.
  // ####################################################################

  // A disable bit wins over an enable bit for the same counter.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      enables  <= '0;
      counters <= '0;
    end else begin
      for (int i = 0; i < numCounters; i++) begin
        if (clearMask[i]) begin
          counters[i] <= '0;
        end else if (enables[i] && events[i]) begin
          counters[i] <= counters[i] + ciDataWidth'(1);
        end
      end
      if (start) begin
        enables <= (enables | operands.dataB[2:0]) & ~operands.dataB[6:4];
      end
    end
  end

  // ####################################################################
  // Read back.
  // ####################################################################

  // Reads see the counter value from before this start's control.
  always_comb begin
    case (operands.dataA[1:0])
      2'd0:    selected = counters[0];
      2'd1:    selected = counters[1];
      2'd2:    selected = counters[2];
      default: selected = '0;
    endcase
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      response <= '0;
    end else begin
      response.done   <= start;
      response.result <= start ? selected : '0;
    end
  end

endmodule

`default_nettype wire

// ==== design/ciResultCollector.sv ====
`timescale 1ns/10ps
`default_nettype none

module ciResultCollector (
  input  wire                 s_systemClock,
  input  wire                 s_pllLocked,
  input  wire ciPkg::ciIssue_t    issue,
  input  wire ciPkg::ciResponse_t byteResponse,
  input  wire ciPkg::ciResponse_t delayResponse,
  input  wire ciPkg::ciResponse_t profileResponse,
  output ciPkg::ciResponse_t  response
);

  import ciPkg::*;

  logic        anyIssue;
  logic        busy;
  ciResponse_t merged;

  assign anyIssue = |issue;

  // Idle units drive zero, so an OR is enough to merge them.
  always_comb begin
    merged.done   = byteResponse.done | delayResponse.done | profileResponse.done |
                    issue.unknownStart;
    merged.result = byteResponse.result | delayResponse.result | profileResponse.result |
                    (issue.unknownStart ? ciUnknownResult : '0);
  end

  // An unknown opcode is answered in the cycle it arrives and never
  // leaves the collector busy.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      busy     <= 1'b0;
      response <= '0;
    end else begin
      response <= merged;
      if (merged.done) begin
        busy <= 1'b0;
      end else if (anyIssue) begin
        busy <= 1'b1;
      end
    end
  end

  unitDoneOneHot : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    $onehot0({byteResponse.done, delayResponse.done, profileResponse.done})
  ) else $error("ciResultCollector: more than one unit reports done");

  noIssueWhileBusy : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    anyIssue |-> !busy
  ) else $error("ciResultCollector: new instruction issued before done");

endmodule

`default_nettype wire

// ==== design/customInstructionTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module customInstructionTop #(
  parameter int resetStretchCycles   = 16,
  parameter int cyclesPerMicrosecond = 5
) (
  input  wire                s_systemClock,
  input  wire                s_pllLocked,
  input  wire ciPkg::ciRequest_t request,
  input  wire                stall,
  input  wire                busIdle,
  output ciPkg::ciResponse_t response,
  output logic               ready
);

  import ciPkg::*;

  ciIssue_t    issue;
  ciResponse_t byteResponse;
  ciResponse_t delayResponse;
  ciResponse_t profileResponse;

  ciDecoder #(.resetStretchCycles(resetStretchCycles)) decoder_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .request      (request),
    .ready        (ready),
    .issue        (issue)
  );

  ciByteUnit byteUnit_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .start        (issue.byteStart),
    .operands     (request.operands),
    .response     (byteResponse)
  );

  ciDelayUnit #(.cyclesPerMicrosecond(cyclesPerMicrosecond)) delayUnit_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .start        (issue.delayStart),
    .operands     (request.operands),
    .response     (delayResponse)
  );

  ciProfileUnit profileUnit_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .start        (issue.profileStart),
    .operands     (request.operands),
    .stall        (stall),
    .busIdle      (busIdle),
    .response     (profileResponse)
  );

  ciResultCollector collector_i (
    .s_systemClock  (s_systemClock),
    .s_pllLocked    (s_pllLocked),
    .issue          (issue),
    .byteResponse   (byteResponse),
    .delayResponse  (delayResponse),
    .profileResponse(profileResponse),
    .response       (response)
  );

endmodule

`default_nettype wire

// ==== dv/ciTbTable.svh ====
`ifndef CI_TB_TABLE_SVH
`define CI_TB_TABLE_SVH

// Columns: opcode, dataA, dataB, stall, busIdle, useModel, expected result,
// latency in cycles from the start edge, idle cycles after the row.
// Rows with useModel set take their expected result from the counter model.
typedef struct packed {
  logic [7:0]  opcode;
  logic [31:0] dataA;
  logic [31:0] dataB;
  logic        stall;
  logic        busIdle;
  logic        useModel;
  logic [31:0] expResult;
  logic [7:0]  latency;
  logic [7:0]  idleAfter;
} tableRow_t;

localparam int numRows         = 18;
localparam int disabledReadRow = 14;

localparam tableRow_t testTable [numRows] = '{
  '{ciOpByte,    32'h11223344, 32'h00000000, 1'b0, 1'b0, 1'b0, 32'h44332211, 8'd2,  8'd0},
  '{ciOpByte,    32'h11223344, 32'h00000001, 1'b0, 1'b0, 1'b0, 32'h33441122, 8'd2,  8'd0},
  '{ciOpByte,    32'h11223344, 32'h00000002, 1'b0, 1'b0, 1'b0, 32'h22114433, 8'd2,  8'd0},
  '{ciOpByte,    32'h11223344, 32'h00000003, 1'b0, 1'b0, 1'b0, 32'h11223344, 8'd2,  8'd0},
  '{ciOpByte,    32'hA1B2C3D4, 32'hFFFFFFFC, 1'b0, 1'b0, 1'b0, 32'hD4C3B2A1, 8'd2,  8'd1},
  // Delay latency is 1 + max(1, dataA * 5).
  '{ciOpDelay,   32'h00000000, 32'h00000000, 1'b0, 1'b0, 1'b0, 32'h00000000, 8'd2,  8'd0},
  '{ciOpDelay,   32'h00000001, 32'h00000000, 1'b0, 1'b0, 1'b0, 32'h00000000, 8'd6,  8'd0},
  '{ciOpDelay,   32'h00000003, 32'h00000000, 1'b0, 1'b0, 1'b0, 32'h00000000, 8'd16, 8'd2},
  '{ciOpProfile, 32'h00000000, 32'h00000700, 1'b0, 1'b0, 1'b1, 32'h00000000, 8'd2,  8'd0},
  '{ciOpProfile, 32'h00000000, 32'h00000007, 1'b1, 1'b0, 1'b1, 32'h00000000, 8'd2,  8'd10},
  '{ciOpProfile, 32'h00000000, 32'h00000000, 1'b1, 1'b0, 1'b1, 32'h00000000, 8'd2,  8'd0},
  '{ciOpProfile, 32'h00000001, 32'h00000000, 1'b1, 1'b0, 1'b1, 32'h00000000, 8'd2,  8'd0},
  '{ciOpProfile, 32'h00000002, 32'h00000000, 1'b1, 1'b0, 1'b0, 32'h00000000, 8'd2,  8'd0},
  '{ciOpProfile, 32'h00000001, 32'h00000070, 1'b1, 1'b0, 1'b1, 32'h00000000, 8'd2,  8'd0},
  '{ciOpProfile, 32'h00000001, 32'h00000000, 1'b1, 1'b0, 1'b1, 32'h00000000, 8'd2,  8'd5},
  '{ciOpProfile, 32'h00000001, 32'h00000000, 1'b0, 1'b0, 1'b1, 32'h00000000, 8'd2,  8'd0},
  '{ciOpProfile, 32'h00000003, 32'h00000000, 1'b0, 1'b0, 1'b0, 32'h00000000, 8'd2,  8'd0},
  '{8'h42,       32'h12345678, 32'h9ABCDEF0, 1'b0, 1'b0, 1'b0, 32'hFFFFFFFF, 8'd1,  8'd0}
};

`endif

// ==== dv/ciTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module ciTb;

  import ciPkg::*;

  `include "ciTbTable.svh"

  localparam int clockPeriod = 4;
  localparam int randomOps   = 20;

  logic        s_systemClock;
  logic        s_pllLocked;
  ciRequest_t  request;
  logic        stall;
  logic        busIdle;
  ciResponse_t response;
  logic        ready;

  int          testCount;
  int          failedTests;
  int          errorCount;
  int          errorsBefore;
  int          readyEdge;
  integer      seed;
  logic        gotDone;
  int          latency;
  logic [31:0] result;
  logic [31:0] expResult;
  logic [31:0] dataA;
  logic [31:0] dataB;
  logic [31:0] rowResult [numRows];

  // Reference model of the profiling counters, fed by the driven stimulus.
  logic [ciDataWidth-1:0] modelCount [3];
  logic [2:0]             modelEnable;
  logic [ciDataWidth-1:0] modelRead;
  logic                   modelStart;
  logic [2:0]             modelEvents;

  customInstructionTop dut_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .request      (request),
    .stall        (stall),
    .busIdle      (busIdle),
    .response     (response),
    .ready        (ready)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #(clockPeriod / 2) s_systemClock = ~s_systemClock;
  end

  assign modelStart  = request.start && (request.opcode == ciOpProfile);
  assign modelEvents = {busIdle, stall, 1'b1};

  always @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      modelCount  <= '{default: '0};
      modelEnable <= '0;
      modelRead   <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (modelStart && request.operands.dataB[8 + i]) begin
          modelCount[i] <= '0;
        end else if (modelEnable[i] && modelEvents[i]) begin
          modelCount[i] <= modelCount[i] + 1;
        end
      end
      if (modelStart) begin
        modelEnable <= (modelEnable | request.operands.dataB[2:0]) & ~request.operands.dataB[6:4];
        modelRead   <= (request.operands.dataA[1:0] == 2'd3) ? '0 :
                       modelCount[request.operands.dataA[1:0]];
      end
    end
  end

  // ####################################################################
  // Helpers.
  // ####################################################################

  // Output byte i takes input byte src, as the byte mode defines it.
  function automatic logic [31:0] expectedSwap(input logic [31:0] value, input byteMode_t mode);
    logic [31:0] swapped;
    int          src;
    for (int i = 0; i < 4; i++) begin
      case (mode)
        reverseBytes: src = 3 - i;
        swapHalves:   src = i ^ 2;
        swapInHalves: src = i ^ 1;
        default:      src = i;
      endcase
      swapped[8*i +: 8] = value[8*src +: 8];
    end
    return swapped;
  endfunction

  function automatic string opcodeName(input logic [7:0] opcode);
    case (opcode)
      ciOpByte:    return "byte";
      ciOpDelay:   return "delay";
      ciOpProfile: return "profile";
      default:     return "unknown";
    endcase
  endfunction

  function automatic int watchdogCycles();
    int total;
    total = 4 + 20 + randomOps * 8;
    for (int r = 0; r < numRows; r++) begin
      total += testTable[r].latency + testTable[r].idleAfter + 4;
    end
    return 2 * total + 100;
  endfunction

  // Entered and left 1 ns after a rising edge.
  task automatic runInstruction(input logic [7:0] opcode, input logic [31:0] a,
                                input logic [31:0] b, input logic stallLevel,
                                input logic idleLevel, input int maxCycles,
                                output logic done, output int cycles,
                                output logic [31:0] value);
    int cycle;
    request.start          = 1'b1;
    request.opcode         = opcode;
    request.operands.dataA = a;
    request.operands.dataB = b;
    stall                  = stallLevel;
    busIdle                = idleLevel;
    done   = 1'b0;
    cycles = 0;
    value  = '0;
    @(posedge s_systemClock);
    #1;
    request = '0;
    cycle   = 0;
    while (!done && cycle < maxCycles) begin
      cycle++;
      @(negedge s_systemClock);
      if (response.done) begin
        done   = 1'b1;
        cycles = cycle;
        value  = response.result;
      end
    end
    @(posedge s_systemClock);
    #1;
  endtask

  task automatic closeTest(input string name, input int errorsAtStart);
    testCount++;
    if (errorCount != errorsAtStart) begin
      failedTests++;
    end
    $display("Test %0d %s: %s", testCount, name,
             (errorCount == errorsAtStart) ? "passed" : "failed");
  endtask

  task automatic checkResponse(input string name, input logic done, input int cycles,
                               input int expCycles, input logic [31:0] value,
                               input logic [31:0] expValue);
    int errorsAtStart;
    errorsAtStart = errorCount;
    assert (done) else begin
      $display("No response done arrived for %s", name);
      errorCount++;
    end
    if (done) begin
      assert (cycles == expCycles) else begin
        $display("Response done came after %0d cycles instead of %0d", cycles, expCycles);
        errorCount++;
      end
      assert (value == expValue) else begin
        $display("** Error: response.result = 0x%08h, expected 0x%08h", value, expValue);
        errorCount++;
      end
    end
    closeTest(name, errorsAtStart);
  endtask

  // ####################################################################
  // Main sequence.
  // ####################################################################

  initial begin
    s_pllLocked = 1'b0;
    request     = '0;
    stall       = 1'b0;
    busIdle     = 1'b0;
    testCount   = 0;
    failedTests = 0;
    errorCount  = 0;
    seed        = 32'h19a0ed74;

    errorsBefore = errorCount;
    repeat (4) begin
      @(posedge s_systemClock);
      #1;
      assert (!ready) else begin
        $display("** Error: ready = 0x%0h, expected 0x0", ready);
        errorCount++;
      end
      assert (!response.done) else begin
        $display("** Error: response.done = 0x%0h, expected 0x0", response.done);
        errorCount++;
      end
    end
    s_pllLocked = 1'b1;

    // An early byte start is sampled at edge 3, long before ready.
    readyEdge = 0;
    for (int edgeCount = 1; edgeCount <= 20; edgeCount++) begin
      @(posedge s_systemClock);
      #1;
      if (edgeCount == 2) begin
        request.start    = 1'b1;
        request.opcode   = ciOpByte;
        request.operands = {32'h11223344, 32'h0};
      end else begin
        request = '0;
      end
      @(negedge s_systemClock);
      if (ready && readyEdge == 0) begin
        readyEdge = edgeCount;
      end
      assert (!response.done) else begin
        $display("A start issued before ready produced a done after edge %0d", edgeCount);
        errorCount++;
      end
    end
    assert (readyEdge == resetStretch()) else begin
      $display("Ready rose after %0d edges instead of 16", readyEdge);
      errorCount++;
    end
    closeTest("reset and ready", errorsBefore);
    @(posedge s_systemClock);
    #1;

    for (int r = 0; r < numRows; r++) begin
      runInstruction(testTable[r].opcode, testTable[r].dataA, testTable[r].dataB,
                     testTable[r].stall, testTable[r].busIdle, testTable[r].latency + 10,
                     gotDone, latency, result);
      expResult    = testTable[r].useModel ? modelRead : testTable[r].expResult;
      rowResult[r] = result;
      checkResponse($sformatf("row %0d %s", r, opcodeName(testTable[r].opcode)), gotDone,
                    latency, testTable[r].latency, result, expResult);
      repeat (testTable[r].idleAfter) begin
        @(posedge s_systemClock);
        #1;
      end
    end

    // Two reads after the disable must see the same stall count.
    errorsBefore = errorCount;
    assert (rowResult[disabledReadRow + 1] == rowResult[disabledReadRow]) else begin
      $display("** Error: response.result = 0x%08h, expected 0x%08h",
               rowResult[disabledReadRow + 1], rowResult[disabledReadRow]);
      errorCount++;
    end
    closeTest("profile hold after disable", errorsBefore);

    for (int n = 0; n < randomOps; n++) begin
      dataA = $random(seed);
      dataB = $random(seed);
      runInstruction(ciOpByte, dataA, dataB, 1'b0, 1'b0, 12, gotDone, latency, result);
      checkResponse($sformatf("random byte %0d mode %0d", n, dataB[1:0]), gotDone, latency,
                    2, result, expectedSwap(dataA, byteMode_t'(dataB[1:0])));
    end

    $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
    if (failedTests == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  function automatic int resetStretch();
    return 16;
  endfunction

  initial begin
    int limitCycles;
    limitCycles = watchdogCycles();
    #(limitCycles * clockPeriod);
    $display("Watchdog expired after %0d cycles before the tests finished", limitCycles);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+dv
design/ciPkg.sv
design/ciDecoder.sv
design/ciByteUnit.sv
design/ciDelayUnit.sv
design/ciProfileUnit.sv
design/ciResultCollector.sv
design/customInstructionTop.sv
dv/ciTb.sv

// ==== Bender.yml ====
package:
  name: customInstruction

sources:
  - files:
      - design/ciPkg.sv
      - design/ciDecoder.sv
      - design/ciByteUnit.sv
      - design/ciDelayUnit.sv
      - design/ciProfileUnit.sv
      - design/ciResultCollector.sv
      - design/customInstructionTop.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/ciTb.sv
